/* common/accel_defines.svh */
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// ==============================
// Datapath sizes
// ==============================
`define ACCEL_DATA_WIDTH  16       // Input stream word and buffer word
`define ACCEL_ACC_WIDTH   32       // Lane sum and output stream word
`define ACCEL_NUM_BANKS   4        // Banks per buffer, one MAC lane each
`define ACCEL_BANK_DEPTH  16       // Rows per bank
`define ACCEL_ROW_WIDTH   4        // Row address bits
`define ACCEL_BATCH_WIDTH 3        // Batch counter bits

// Packet magic, also upper half of the result header
`define ACCEL_MAGIC       16'hC0DE

`endif

/* common/accel_pkg.sv */
`include "accel_defines.svh"

package accel_pkg;

    // Vector types with a meaning
    typedef logic [`ACCEL_DATA_WIDTH-1:0]  data_t;
    typedef logic [`ACCEL_ACC_WIDTH-1:0]   acc_t;
    typedef logic [`ACCEL_ROW_WIDTH-1:0]   row_t;
    typedef logic [`ACCEL_ROW_WIDTH:0]     row_count_t;   // 0 .. BANK_DEPTH
    typedef logic [$clog2(`ACCEL_NUM_BANKS)-1:0] bank_sel_t;
    typedef logic [`ACCEL_NUM_BANKS-1:0]   bank_mask_t;   // One bit per bank
    typedef logic [`ACCEL_NUM_BANKS-1:0][`ACCEL_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [`ACCEL_NUM_BANKS-1:0][`ACCEL_ACC_WIDTH-1:0]  lane_acc_t;
    typedef logic [`ACCEL_BATCH_WIDTH-1:0] batch_id_t;

    // Loader packet parser
    typedef enum logic [2:0] {
        PARSE_MAGIC,
        PARSE_COUNT,
        PARSE_PAYLOAD,
        PARSE_LOADED,
        PARSE_DROP
    } parser_state_e;

    typedef enum logic [1:0] {SCHED_IDLE, SCHED_RUN, SCHED_DRAIN} sched_state_e;

    typedef enum logic [1:0] {STREAM_IDLE, STREAM_HEADER, STREAM_DATA} stream_state_e;

endpackage

/* rtl/ingest/stream_loader.sv */
`include "accel_defines.svh"

module stream_loader (
    input  logic                     aclk,
    input  logic                     reset,
    input  accel_pkg::data_t         s_axis_tdata,
    input  logic                     s_axis_tvalid,
    output logic                     s_axis_tready,
    input  logic                     s_axis_tlast,
    input  logic                     consume,
    output accel_pkg::bank_mask_t    wr_en,
    output accel_pkg::row_t          wr_row,
    output accel_pkg::data_t         wr_data,
    output logic                     loaded,
    output accel_pkg::row_count_t    row_count,
    output accel_pkg::parser_state_e parser_state,
    output logic                     error_invalid_magic
);

    accel_pkg::parser_state_e state;
    accel_pkg::bank_sel_t     bank;       // Round-robin bank of next payload word
    accel_pkg::row_t          row;        // Row of next payload word
    logic                     beat;
    logic                     count_ok;
    logic                     last_beat;

    // Back-pressure only while a loaded packet waits for consume
    assign s_axis_tready = (state != accel_pkg::PARSE_LOADED);
    assign beat          = s_axis_tvalid && s_axis_tready;

    assign count_ok  = (s_axis_tdata != '0) && (s_axis_tdata <= `ACCEL_BANK_DEPTH);
    assign last_beat = (bank == accel_pkg::bank_sel_t'(`ACCEL_NUM_BANKS - 1))
                    && (accel_pkg::row_count_t'(row) == row_count - 1'b1);

    // Payload goes straight into the buffer on the accepted beat
    assign wr_en   = (state == accel_pkg::PARSE_PAYLOAD && beat)
                   ? accel_pkg::bank_mask_t'(1'b1) << bank : '0;
    assign wr_row  = row;
    assign wr_data = s_axis_tdata;

    assign loaded       = (state == accel_pkg::PARSE_LOADED);
    assign parser_state = state;

    // ==============================
    // Packet parser FSM
    // ==============================
    always_ff @(posedge aclk) begin
        if (reset) begin
            state               <= accel_pkg::PARSE_MAGIC;
            bank                <= '0;
            row                 <= '0;
            row_count           <= '0;
            error_invalid_magic <= 1'b0;
        end else begin
            case (state)
                accel_pkg::PARSE_MAGIC: begin
                    if (beat) begin
                        if (s_axis_tdata != `ACCEL_MAGIC) begin
                            error_invalid_magic <= 1'b1;   // Sticky until reset
                            state <= s_axis_tlast ? accel_pkg::PARSE_MAGIC
                                                  : accel_pkg::PARSE_DROP;
                        end else begin
                            state <= accel_pkg::PARSE_COUNT;
                        end
                    end
                end
                accel_pkg::PARSE_COUNT: begin
                    if (beat) begin
                        bank <= '0;
                        row  <= '0;
                        if (count_ok) begin
                            row_count <= accel_pkg::row_count_t'(s_axis_tdata);
                            state     <= accel_pkg::PARSE_PAYLOAD;
                        end else begin
                            // Bad count drops the packet, no error flag
                            state <= s_axis_tlast ? accel_pkg::PARSE_MAGIC
                                                  : accel_pkg::PARSE_DROP;
                        end
                    end
                end
                accel_pkg::PARSE_PAYLOAD: begin
                    if (beat) begin
                        bank <= bank + 1'b1;                  // Wraps over the banks
                        if (bank == accel_pkg::bank_sel_t'(`ACCEL_NUM_BANKS - 1))
                            row <= row + 1'b1;
                        if (last_beat)
                            state <= accel_pkg::PARSE_LOADED;
                    end
                end
                accel_pkg::PARSE_LOADED: begin
                    if (consume)
                        state <= accel_pkg::PARSE_MAGIC;      // Buffer handed to batch
                end
                accel_pkg::PARSE_DROP: begin
                    if (beat && s_axis_tlast)
                        state <= accel_pkg::PARSE_MAGIC;      // Resync on packet end
                end
                default: state <= accel_pkg::PARSE_MAGIC;
            endcase
        end
    end

endmodule

/* rtl/ingest/bank_buffer.sv */
`include "accel_defines.svh"

module bank_buffer (
    input  logic                  aclk,
    input  accel_pkg::bank_mask_t wr_en,
    input  accel_pkg::row_t       wr_row,
    input  accel_pkg::data_t      wr_data,
    input  accel_pkg::row_t       rd_row,
    output accel_pkg::bank_data_t rd_data
);

    // One memory per bank, same row address on every bank
    for (genvar b = 0; b < `ACCEL_NUM_BANKS; b++) begin : g_bank
        accel_pkg::data_t mem [`ACCEL_BANK_DEPTH];

        always_ff @(posedge aclk) begin
            if (wr_en[b])
                mem[wr_row] <= wr_data;
            rd_data[b] <= mem[rd_row];   // Registered read, one cycle latency
        end
    end

endmodule

/* rtl/batch_scheduler.sv */
module batch_scheduler (
    input  logic                  aclk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  weight_loaded,
    input  logic                  ifmap_loaded,
    input  accel_pkg::row_count_t weight_rows,
    input  accel_pkg::row_count_t ifmap_rows,
    input  logic                  stream_idle,
    output logic                  consume,
    output accel_pkg::row_t       rd_row,
    output logic                  mac_en,
    output logic                  mac_first,
    output logic                  results_valid,
    output logic                  busy,
    output accel_pkg::batch_id_t  batch_id
);

    accel_pkg::sched_state_e state;
    accel_pkg::row_count_t   run_rows;     // Rows used by this batch
    accel_pkg::row_t         row;
    logic                    start_pending;
    logic                    go;
    logic                    last_read;

    assign go = start_pending && weight_loaded && ifmap_loaded && stream_idle
             && (state == accel_pkg::SCHED_IDLE);
    assign last_read = (accel_pkg::row_count_t'(row) == run_rows - 1'b1);

    assign rd_row = row;
    assign busy   = (state != accel_pkg::SCHED_IDLE);

    // ==============================
    // Row sequencing
    // ==============================
    always_ff @(posedge aclk) begin
        if (reset) begin
            state         <= accel_pkg::SCHED_IDLE;
            start_pending <= 1'b0;
            run_rows      <= '0;
            row           <= '0;
            consume       <= 1'b0;
            mac_en        <= 1'b0;
            mac_first     <= 1'b0;
            results_valid <= 1'b0;
            batch_id      <= '0;
        end else begin
            start_pending <= (start_pending || start) && !go;   // Held until batch begins
            consume       <= go;                                // First RUN cycle
            // Enables trail the read by one cycle of buffer latency
            mac_en        <= (state == accel_pkg::SCHED_RUN);
            mac_first     <= (state == accel_pkg::SCHED_RUN) && (row == '0);
            results_valid <= (state == accel_pkg::SCHED_DRAIN);
            // Streamer takes the finished batch's id with the sums
            if (results_valid)
                batch_id <= batch_id + 1'b1;   // Wraps after the last id
            case (state)
                accel_pkg::SCHED_IDLE: begin
                    if (go) begin
                        // Shorter packet bounds the batch
                        run_rows <= (weight_rows < ifmap_rows) ? weight_rows : ifmap_rows;
                        row      <= '0;
                        state    <= accel_pkg::SCHED_RUN;
                    end
                end
                accel_pkg::SCHED_RUN: begin
                    if (last_read) begin
                        row   <= '0;
                        state <= accel_pkg::SCHED_DRAIN;
                    end else begin
                        row <= row + 1'b1;
                    end
                end
                accel_pkg::SCHED_DRAIN: begin
                    state <= accel_pkg::SCHED_IDLE;   // Last sum registers here
                end
                default: state <= accel_pkg::SCHED_IDLE;
            endcase
        end
    end

endmodule

/* rtl/mac_array.sv */
`include "accel_defines.svh"

module mac_array (
    input  logic                  aclk,
    input  logic                  reset,
    input  logic                  mac_en,
    input  logic                  mac_first,
    input  accel_pkg::bank_data_t weight_row,
    input  accel_pkg::bank_data_t ifmap_row,
    output accel_pkg::lane_acc_t  lane_sums
);

    // ==============================
    // One MAC lane per bank
    // ==============================
    for (genvar l = 0; l < `ACCEL_NUM_BANKS; l++) begin : g_lane
        logic signed [2*`ACCEL_DATA_WIDTH-1:0] product;
        accel_pkg::acc_t                       product_ext;

        assign product     = $signed(weight_row[l]) * $signed(ifmap_row[l]);
        assign product_ext = accel_pkg::acc_t'(product);   // Sign extended to sum width

        always_ff @(posedge aclk) begin
            if (reset)
                lane_sums[l] <= '0;
            else if (mac_en)
                // First row restarts the sum, wraps modulo 2**ACC_WIDTH
                lane_sums[l] <= mac_first ? product_ext : lane_sums[l] + product_ext;
        end
    end

endmodule

/* rtl/result_streamer.sv */
`include "accel_defines.svh"

module result_streamer (
    input  logic                 aclk,
    input  logic                 reset,
    input  logic                 results_valid,
    input  accel_pkg::lane_acc_t lane_sums,
    input  accel_pkg::batch_id_t batch_id,
    output accel_pkg::acc_t      m_axis_tdata,
    output logic                 m_axis_tvalid,
    input  logic                 m_axis_tready,
    output logic                 m_axis_tlast,
    output logic                 idle
);

    accel_pkg::stream_state_e state;
    accel_pkg::lane_acc_t     sums_q;     // Captured lane sums
    accel_pkg::batch_id_t     batch_q;    // Batch id for the header
    accel_pkg::bank_sel_t     lane;       // Lane being sent
    accel_pkg::acc_t          header;

    assign header = {`ACCEL_MAGIC, {(`ACCEL_ACC_WIDTH - 16 - `ACCEL_BATCH_WIDTH){1'b0}}, batch_q};

    // Outputs come from registers only, stable while tready is low
    assign m_axis_tvalid = (state != accel_pkg::STREAM_IDLE);
    assign m_axis_tdata  = (state == accel_pkg::STREAM_HEADER) ? header : sums_q[lane];
    assign m_axis_tlast  = (state == accel_pkg::STREAM_DATA)
                        && (lane == accel_pkg::bank_sel_t'(`ACCEL_NUM_BANKS - 1));
    assign idle = (state == accel_pkg::STREAM_IDLE) && !results_valid;   // Low from capture on

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= accel_pkg::STREAM_IDLE;
            lane  <= '0;
        end else begin
            case (state)
                accel_pkg::STREAM_IDLE: begin
                    if (results_valid)
                        state <= accel_pkg::STREAM_HEADER;
                end
                accel_pkg::STREAM_HEADER: begin
                    if (m_axis_tready) begin
                        lane  <= '0;
                        state <= accel_pkg::STREAM_DATA;
                    end
                end
                accel_pkg::STREAM_DATA: begin
                    if (m_axis_tready) begin
                        lane <= lane + 1'b1;
                        if (m_axis_tlast)
                            state <= accel_pkg::STREAM_IDLE;   // Packet fully accepted
                    end
                end
                default: state <= accel_pkg::STREAM_IDLE;
            endcase
        end
    end

    // Result capture
    always_ff @(posedge aclk) begin
        if (results_valid && state == accel_pkg::STREAM_IDLE) begin
            sums_q  <= lane_sums;
            batch_q <= batch_id;
        end
    end

endmodule

/* rtl/accel_top.sv */
module accel_top (
    input  logic                     aclk,
    input  logic                     reset,
    // Weight stream
    input  accel_pkg::data_t         s0_axis_tdata,
    input  logic                     s0_axis_tvalid,
    output logic                     s0_axis_tready,
    input  logic                     s0_axis_tlast,
    // Ifmap stream
    input  accel_pkg::data_t         s1_axis_tdata,
    input  logic                     s1_axis_tvalid,
    output logic                     s1_axis_tready,
    input  logic                     s1_axis_tlast,
    // Result stream
    output accel_pkg::acc_t          m_axis_tdata,
    output logic                     m_axis_tvalid,
    input  logic                     m_axis_tready,
    output logic                     m_axis_tlast,
    // Control and status
    input  logic                     start,
    output logic                     busy,
    output accel_pkg::batch_id_t     batch_id,
    output logic                     weight_loaded,
    output logic                     ifmap_loaded,
    output accel_pkg::parser_state_e weight_parser_state,
    output accel_pkg::parser_state_e ifmap_parser_state,
    output logic                     weight_error_invalid_magic,
    output logic                     ifmap_error_invalid_magic
);

    // ==============================
    // Internal wires
    // ==============================
    accel_pkg::bank_mask_t weight_wr_en, ifmap_wr_en;
    accel_pkg::row_t       weight_wr_row, ifmap_wr_row;
    accel_pkg::data_t      weight_wr_data, ifmap_wr_data;
    accel_pkg::row_count_t weight_rows, ifmap_rows;
    accel_pkg::bank_data_t weight_rd_data, ifmap_rd_data;
    accel_pkg::row_t       rd_row;
    accel_pkg::lane_acc_t  lane_sums;
    logic                  consume;
    logic                  mac_en;
    logic                  mac_first;
    logic                  results_valid;
    logic                  stream_idle;

    stream_loader weight_loader (
        .aclk, .reset,
        .s_axis_tdata(s0_axis_tdata), .s_axis_tvalid(s0_axis_tvalid),
        .s_axis_tready(s0_axis_tready), .s_axis_tlast(s0_axis_tlast),
        .consume,
        .wr_en(weight_wr_en), .wr_row(weight_wr_row), .wr_data(weight_wr_data),
        .loaded(weight_loaded), .row_count(weight_rows),
        .parser_state(weight_parser_state),
        .error_invalid_magic(weight_error_invalid_magic)
    );

    stream_loader ifmap_loader (
        .aclk, .reset,
        .s_axis_tdata(s1_axis_tdata), .s_axis_tvalid(s1_axis_tvalid),
        .s_axis_tready(s1_axis_tready), .s_axis_tlast(s1_axis_tlast),
        .consume,
        .wr_en(ifmap_wr_en), .wr_row(ifmap_wr_row), .wr_data(ifmap_wr_data),
        .loaded(ifmap_loaded), .row_count(ifmap_rows),
        .parser_state(ifmap_parser_state),
        .error_invalid_magic(ifmap_error_invalid_magic)
    );

    bank_buffer weight_buffer (
        .aclk, .wr_en(weight_wr_en), .wr_row(weight_wr_row), .wr_data(weight_wr_data),
        .rd_row, .rd_data(weight_rd_data)
    );

    bank_buffer ifmap_buffer (
        .aclk, .wr_en(ifmap_wr_en), .wr_row(ifmap_wr_row), .wr_data(ifmap_wr_data),
        .rd_row, .rd_data(ifmap_rd_data)
    );

    batch_scheduler scheduler (
        .aclk, .reset, .start,
        .weight_loaded, .ifmap_loaded, .weight_rows, .ifmap_rows,
        .stream_idle, .consume, .rd_row, .mac_en, .mac_first,
        .results_valid, .busy, .batch_id
    );

    mac_array macs (
        .aclk, .reset, .mac_en, .mac_first,
        .weight_row(weight_rd_data), .ifmap_row(ifmap_rd_data), .lane_sums
    );

    result_streamer streamer (
        .aclk, .reset, .results_valid, .lane_sums, .batch_id,
        .m_axis_tdata, .m_axis_tvalid, .m_axis_tready, .m_axis_tlast,
        .idle(stream_idle)
    );

endmodule

/* dv/accel_tb_tasks.svh */
`ifndef ACCEL_TB_TASKS_SVH
`define ACCEL_TB_TASKS_SVH

// ==============================
// Stimulus and drivers
// ==============================
function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;   // Xorshift32
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

// Random words, or one constant in every word
function automatic void fill_words(input bit random, input accel_pkg::data_t value);
    logic [31:0] r;
    for (int i = 0; i < NUM_WORDS; i++) begin
        r = next_rand();
        wgt_words[i] = random ? r[15:0] : value;
        ifm_words[i] = random ? r[31:16] : value;
    end
endfunction

task automatic next_cycle();
    @(posedge aclk);
    #10;   // Inputs change just after the edge
endtask

task automatic pulse_start();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
endtask

// Port 0 is weight, port 1 is ifmap; beat held until accepted
task automatic drive_beat(input bit port, input accel_pkg::data_t data, input bit last);
    bit done;
    done = 1'b0;
    if (port == 1'b0) begin
        s0_axis_tdata  = data;
        s0_axis_tvalid = 1'b1;
        s0_axis_tlast  = last;
    end else begin
        s1_axis_tdata  = data;
        s1_axis_tvalid = 1'b1;
        s1_axis_tlast  = last;
    end
    while (!done) begin
        @(negedge aclk);
        done = port ? s1_axis_tready : s0_axis_tready;
        next_cycle();
    end
endtask

task automatic send_packet(input bit port, input accel_pkg::data_t magic, input int rows);
    drive_beat(port, magic, 1'b0);
    drive_beat(port, accel_pkg::data_t'(rows), 1'b0);
    for (int i = 0; i < rows * NB; i++)
        drive_beat(port, port ? ifm_words[i] : wgt_words[i], i == rows * NB - 1);
    if (port)
        s1_axis_tvalid = 1'b0;
    else
        s0_axis_tvalid = 1'b0;
endtask

task automatic send_weight_packet(input accel_pkg::data_t magic, input int rows);
    send_packet(1'b0, magic, rows);
endtask

task automatic send_ifmap_packet(input accel_pkg::data_t magic, input int rows);
    send_packet(1'b1, magic, rows);
endtask

// ==============================
// Reference model
// ==============================
// Word i sits in bank i mod NB at row i / NB
function automatic accel_pkg::lane_acc_t model_sums(input int rows);
    accel_pkg::lane_acc_t sums;
    int                   product;
    sums = '0;
    for (int r = 0; r < rows; r++) begin
        for (int l = 0; l < NB; l++) begin
            product = $signed(wgt_words[r * NB + l]) * $signed(ifm_words[r * NB + l]);
            sums[l] = sums[l] + accel_pkg::acc_t'(product);   // Wraps at ACC_WIDTH
        end
    end
    return sums;
endfunction

// Magic in the top half, batch number in the low bits
function automatic accel_pkg::acc_t header_word(input accel_pkg::batch_id_t b);
    accel_pkg::acc_t h;
    h = '0;
    h[`ACCEL_ACC_WIDTH-1 -: 16]     = `ACCEL_MAGIC;
    h[`ACCEL_BATCH_WIDTH-1:0] = b;
    return h;
endfunction

// ==============================
// Compare tasks
// ==============================
task automatic check_acc(input string what, input accel_pkg::acc_t exp, input accel_pkg::acc_t act);
    if (act !== exp)
        abort_run($sformatf("ERROR %s: %s expected %h actual %h", test_name, what, exp, act));
endtask

task automatic check_batch(input string what, input accel_pkg::batch_id_t exp,
                           input accel_pkg::batch_id_t act);
    if (act !== exp)
        abort_run($sformatf("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act));
endtask

task automatic check_state(input string what, input accel_pkg::parser_state_e exp,
                           input accel_pkg::parser_state_e act);
    if (act !== exp)
        abort_run($sformatf("ERROR %s: %s expected %s actual %s",
                            test_name, what, exp.name(), act.name()));
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
        abort_run($sformatf("ERROR %s: %s expected %b actual %b", test_name, what, exp, act));
endtask

// Header then NB lane words; optionally checks no batch starts meanwhile
task automatic collect_result(input accel_pkg::acc_t header, input accel_pkg::lane_acc_t sums,
                              input bit random_ready, input bit no_new_batch);
    int              idx;
    logic [31:0]     r;
    accel_pkg::acc_t exp;
    idx = 0;
    while (idx <= NB) begin
        r = next_rand();
        m_axis_tready = random_ready ? r[0] : 1'b1;
        @(negedge aclk);
        if (no_new_batch && m_axis_tvalid)
            check_bit("busy before packet accepted", 1'b0, busy);
        if (m_axis_tvalid && m_axis_tready) begin
            if (idx == 0)
                exp = header;
            else
                exp = sums[idx - 1];
            check_acc($sformatf("result word %0d", idx), exp, m_axis_tdata);
            if (idx == NB && !m_axis_tlast)
                abort_run("Last result word arrived without tlast");
            check_bit($sformatf("tlast on word %0d", idx), idx == NB, m_axis_tlast);
            idx++;
        end
        next_cycle();
    end
    m_axis_tready = 1'b0;
endtask

`endif

/* dv/accel_tb.sv */
`include "accel_defines.svh"

module accel_tb;

    localparam int NB          = `ACCEL_NUM_BANKS;
    localparam int NUM_WORDS   = `ACCEL_NUM_BANKS * `ACCEL_BANK_DEPTH;
    localparam int CYCLE_LIMIT = 20000;   // Six tests of at most 2000 cycles each, plus margin

    // DUT inputs, all defined from time 0
    logic                     aclk = 1'b0;
    logic                     reset = 1'b1;
    accel_pkg::data_t         s0_axis_tdata = '0;
    logic                     s0_axis_tvalid = 1'b0;
    logic                     s0_axis_tlast = 1'b0;
    accel_pkg::data_t         s1_axis_tdata = '0;
    logic                     s1_axis_tvalid = 1'b0;
    logic                     s1_axis_tlast = 1'b0;
    logic                     m_axis_tready = 1'b0;
    logic                     start = 1'b0;
    // DUT outputs
    logic                     s0_axis_tready, s1_axis_tready;
    accel_pkg::acc_t          m_axis_tdata;
    logic                     m_axis_tvalid, m_axis_tlast, busy;
    accel_pkg::batch_id_t     batch_id;
    logic                     weight_loaded, ifmap_loaded;
    accel_pkg::parser_state_e weight_parser_state, ifmap_parser_state;
    logic                     weight_error_invalid_magic, ifmap_error_invalid_magic;

    logic [31:0]      rng_state = 32'h707af634;
    int unsigned      cycles = 0;
    int               batches = 0;             // Batches started so far
    string            test_name = "reset";
    accel_pkg::data_t wgt_words [NUM_WORDS];   // Payload of the next weight packet
    accel_pkg::data_t ifm_words [NUM_WORDS];   // Payload of the next ifmap packet

    always #50 aclk = ~aclk;

    accel_top i_dut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // ==============================
    // Run length guard
    // ==============================
    always @(posedge aclk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT)
            abort_run($sformatf("Timeout, run still going after %0d cycles", CYCLE_LIMIT));
    end

    `include "accel_tb_tasks.svh"

    // Load both ports, start, check the result packet
    task automatic run_batch(input int wrows, input int irows, input bit random_ready);
        accel_pkg::lane_acc_t exp;
        exp = model_sums(wrows < irows ? wrows : irows);   // Shorter packet bounds the batch
        send_weight_packet(`ACCEL_MAGIC, wrows);
        send_ifmap_packet(`ACCEL_MAGIC, irows);
        pulse_start();
        collect_result(header_word(accel_pkg::batch_id_t'(batches)), exp, random_ready, 1'b0);
        batches++;
    endtask

    task automatic test_reset_state();
        test_name = "reset state";
        @(negedge aclk);
        check_bit("m_axis_tvalid", 1'b0, m_axis_tvalid);
        check_bit("busy", 1'b0, busy);
        check_bit("weight_loaded", 1'b0, weight_loaded);
        check_bit("ifmap_loaded", 1'b0, ifmap_loaded);
        check_bit("weight error", 1'b0, weight_error_invalid_magic);
        check_bit("ifmap error", 1'b0, ifmap_error_invalid_magic);
        check_batch("batch_id", '0, batch_id);
        check_state("weight parser", accel_pkg::PARSE_MAGIC, weight_parser_state);
        check_state("ifmap parser", accel_pkg::PARSE_MAGIC, ifmap_parser_state);
        check_bit("s0_axis_tready", 1'b1, s0_axis_tready);
        check_bit("s1_axis_tready", 1'b1, s1_axis_tready);
        next_cycle();
    endtask

    task automatic test_output_backpressure();
        accel_pkg::lane_acc_t exp_a, exp_b;
        test_name = "output back-pressure";
        fill_words(1'b1, '0);
        exp_a = model_sums(16);
        send_weight_packet(`ACCEL_MAGIC, 16);
        send_ifmap_packet(`ACCEL_MAGIC, 16);
        pulse_start();
        fill_words(1'b1, '0);
        exp_b = model_sums(9);
        send_weight_packet(`ACCEL_MAGIC, 9);   // Loads while batch A sits in the streamer
        send_ifmap_packet(`ACCEL_MAGIC, 9);
        pulse_start();                          // Stays pending until A is accepted
        collect_result(header_word(accel_pkg::batch_id_t'(batches)), exp_a, 1'b1, 1'b1);
        collect_result(header_word(accel_pkg::batch_id_t'(batches + 1)), exp_b, 1'b0, 1'b0);
        batches += 2;
    endtask

    task automatic test_bad_magic();
        test_name = "bad magic";
        fill_words(1'b1, '0);
        send_weight_packet(16'h1234, 2);
        @(negedge aclk);
        check_bit("weight error", 1'b1, weight_error_invalid_magic);
        check_bit("weight_loaded", 1'b0, weight_loaded);
        check_state("weight parser", accel_pkg::PARSE_MAGIC, weight_parser_state);
        check_bit("ifmap error", 1'b0, ifmap_error_invalid_magic);
        next_cycle();
        fill_words(1'b0, 16'h8000);   // 5 products of 2**30 overflow the sum
        run_batch(5, 5, 1'b0);
        @(negedge aclk);
        check_bit("sticky weight error", 1'b1, weight_error_invalid_magic);
        next_cycle();
    endtask

    task automatic test_input_backpressure();
        accel_pkg::lane_acc_t exp_a, exp_b;
        test_name = "input back-pressure";
        fill_words(1'b1, '0);
        exp_a = model_sums(4);
        send_weight_packet(`ACCEL_MAGIC, 4);
        send_ifmap_packet(`ACCEL_MAGIC, 4);
        fill_words(1'b1, '0);
        exp_b = model_sums(6);
        fork
            send_weight_packet(`ACCEL_MAGIC, 6);
            begin
                repeat (4) begin
                    @(negedge aclk);
                    check_bit("s0_axis_tready while loaded", 1'b0, s0_axis_tready);
                    check_bit("weight_loaded", 1'b1, weight_loaded);
                end
                next_cycle();
                pulse_start();   // Consume frees the weight port
            end
        join
        collect_result(header_word(accel_pkg::batch_id_t'(batches)), exp_a, 1'b0, 1'b0);
        send_ifmap_packet(`ACCEL_MAGIC, 6);
        pulse_start();
        collect_result(header_word(accel_pkg::batch_id_t'(batches + 1)), exp_b, 1'b0, 1'b0);
        batches += 2;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        repeat (8) @(posedge aclk);
        #10;
        reset = 1'b0;
        test_reset_state();
        test_name = "single batch";
        fill_words(1'b1, '0);
        run_batch(7, 7, 1'b0);
        check_batch("batch_id", accel_pkg::batch_id_t'(1), batch_id);
        test_output_backpressure();
        test_bad_magic();
        test_name = "unequal rows";
        fill_words(1'b1, '0);
        run_batch(5, 3, 1'b0);   // Weight longer than ifmap
        check_batch("batch_id", accel_pkg::batch_id_t'(batches), batch_id);
        test_input_backpressure();
        check_batch("batch_id", accel_pkg::batch_id_t'(batches), batch_id);
        $display("TEST OK");
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
+incdir+dv
common/accel_pkg.sv
rtl/ingest/stream_loader.sv
rtl/ingest/bank_buffer.sv
rtl/batch_scheduler.sv
rtl/mac_array.sv
rtl/result_streamer.sv
rtl/accel_top.sv
dv/accel_tb.sv

/* Bender.yml */
package:
  name: accel_tile

sources:
  - include_dirs:
      - common
    files:
      - common/accel_pkg.sv
      - rtl/ingest/stream_loader.sv
      - rtl/ingest/bank_buffer.sv
      - rtl/batch_scheduler.sv
      - rtl/mac_array.sv
      - rtl/result_streamer.sv
      - rtl/accel_top.sv
  - target: test
    include_dirs:
      - common
      - dv
    files:
      - dv/accel_tb.sv
